// ==== cache_defines.svh ====
// Cache geometry macros
// Two-way set-associative cache, 8 sets of 16-byte lines

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ------------------------------------------------------------
// Widths

`define CACHE_ADDR_W   32
`define CACHE_DATA_W   32
`define CACHE_LINE_W   128   // Four words per line

// ------------------------------------------------------------
// Geometry

`define CACHE_NUM_SETS 8
`define CACHE_NUM_WAYS 2

`define CACHE_OFS_W    4     // Byte offset within a line
`define CACHE_IDX_W    3

`endif

// ==== cache_pkg.sv ====
// Cache types
// Vector typedefs and enums shared by the controller and the way datapath

`include "cache_defines.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_DATA_W-1:0] word_t;
  typedef logic [`CACHE_LINE_W-1:0] line_t;

  // Whole address above the offset, index bits kept in the tag
  typedef logic [`CACHE_ADDR_W-`CACHE_OFS_W-1:0] tag_t;
  typedef logic [`CACHE_IDX_W-1:0]               idx_t;       // addr[6:4]
  typedef logic [`CACHE_OFS_W-3:0]               word_sel_t;  // addr[3:2]
  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0]    way_t;

  typedef enum logic [2:0] {
    req_read  = 3'd0,
    req_write = 3'd1,
    req_init  = 3'd2
  } req_type_e;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  // Controller FSM
  typedef enum logic [3:0] {
    idle, tag_check,
    init_access, read_access, write_access,
    evict_prepare, evict_request, evict_wait,
    refill_request, refill_wait, refill_update,
    wait_resp
  } ctrl_state_e;

endpackage

// ==== way_if.sv ====
// Way bundle
// Controller address and write strobes in, lookup results out of one way

interface way_if;
  import cache_pkg::*;

  // Lookup address from the latched request
  idx_t      idx;
  tag_t      tag;
  word_sel_t word_sel;

  // Write side, each strobe is a single cycle
  logic      tag_wen;    // Tag, valid and dirty together
  logic      line_wen;
  logic      word_wen;
  logic      valid_in;
  logic      dirty_in;
  line_t     line_in;
  word_t     word_in;

  // Lookup results
  logic      match;
  logic      valid;
  logic      dirty;
  tag_t      tag_out;
  line_t     line_out;

  modport ctrl (output idx, tag, word_sel, tag_wen, line_wen, word_wen,
                output valid_in, dirty_in, line_in, word_in);

  modport way (input idx, tag, word_sel, tag_wen, line_wen, word_wen,
               input valid_in, dirty_in, line_in, word_in,
               output match, valid, dirty, tag_out, line_out);

  modport merge (input match, valid, dirty, tag_out, line_out, word_sel);

endinterface

// ==== cache_ctrl.sv ====
// Blocking cache controller
// Request FSM, request latches, per-set LRU and write steering to the ways

`include "cache_defines.svh"

module cache_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  // Processor side
  input  logic                 cachereq_val,
  output logic                 cachereq_rdy,
  input  cache_pkg::req_type_e cachereq_type,
  input  cache_pkg::addr_t     cachereq_addr,
  input  cache_pkg::word_t     cachereq_data,
  output logic                 cacheresp_val,
  input  logic                 cacheresp_rdy,
  output cache_pkg::req_type_e cacheresp_type,
  output logic                 cacheresp_hit,
  // Memory side
  output logic                 memreq_val,
  input  logic                 memreq_rdy,
  output cache_pkg::mem_type_e memreq_type,
  output cache_pkg::addr_t     memreq_addr,
  input  logic                 memresp_val,
  output logic                 memresp_rdy,
  input  cache_pkg::line_t     memresp_data,
  // Merge stage
  input  logic                 hit,
  input  cache_pkg::way_t      hit_way,
  input  logic                 victim_valid,
  input  logic                 victim_dirty,
  input  cache_pkg::tag_t      victim_tag,
  output cache_pkg::way_t      victim_way,
  output logic                 evicting,
  way_if.ctrl                  ways [`CACHE_NUM_WAYS]
);
  import cache_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;

  addr_t     req_addr;
  word_t     req_data;
  req_type_e req_type;
  idx_t      req_idx;
  tag_t      req_tag;
  word_sel_t req_word;

  line_t     refill_line;
  tag_t      evict_tag;
  logic      hit_reg;
  logic [`CACHE_NUM_SETS-1:0] lru;  // Victim way of each set

  way_t      target_way;
  logic      meta_wen;
  logic      line_wen;
  logic      word_wen;

  assign req_idx  = req_addr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign req_tag  = req_addr[`CACHE_ADDR_W-1:`CACHE_OFS_W];
  assign req_word = req_addr[`CACHE_OFS_W-1:2];

  // ------------------------------------------------------------
  // FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle:           if (cachereq_val) state_next = tag_check;
      tag_check: begin
        if (req_type == req_init) begin
          state_next = init_access;
        end else if (hit) begin
          state_next = (req_type == req_write) ? write_access : read_access;
        end else if (victim_valid && victim_dirty) begin
          state_next = evict_prepare;
        end else begin
          state_next = refill_request;
        end
      end
      init_access, read_access, write_access:
        state_next = wait_resp;
      wait_resp:      if (cacheresp_rdy) state_next = idle;
      evict_prepare:  state_next = evict_request;
      evict_request:  if (memreq_rdy) state_next = evict_wait;
      evict_wait:     if (memresp_val) state_next = refill_request;  // Writeback ack
      refill_request: if (memreq_rdy) state_next = refill_wait;
      refill_wait:    if (memresp_val) state_next = refill_update;
      refill_update:
        state_next = (req_type == req_write) ? write_access : read_access;
      default:        state_next = idle;
    endcase
  end

  // Request, hit flag, eviction tag and refill line
  always_ff @(posedge clk) begin
    if (state == idle && cachereq_val) begin
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
      req_type <= cachereq_type;
    end
    if (state == tag_check) begin
      hit_reg <= hit && (req_type != req_init);  // Init always reports a miss
    end
    if (state == evict_prepare) begin
      evict_tag <= victim_tag;
    end
    if (state == refill_wait && memresp_val) begin
      refill_line <= memresp_data;
    end
  end

  // ------------------------------------------------------------
  // LRU, the other way becomes the victim after any use

  always_ff @(posedge clk) begin
    if (reset) begin
      lru <= '0;
    end else begin
      case (state)
        init_access:               lru[req_idx] <= 1'b1;  // Init fills way 0
        read_access, write_access: lru[req_idx] <= ~hit_way;
        refill_update:             lru[req_idx] <= ~victim_way;
        default: ;
      endcase
    end
  end

  assign victim_way = way_t'(lru[req_idx]);

  // ------------------------------------------------------------
  // Write steering

  always_comb begin
    case (state)
      init_access:   target_way = '0;
      refill_update: target_way = victim_way;
      default:       target_way = hit_way;
    endcase
  end

  assign meta_wen = (state == init_access) || (state == write_access) ||
                    (state == refill_update);
  assign line_wen = (state == refill_update);
  assign word_wen = (state == init_access) || (state == write_access);

  for (genvar w = 0; w < `CACHE_NUM_WAYS; w++) begin : g_steer
    logic sel;
    assign sel              = (target_way == way_t'(w));
    assign ways[w].idx      = req_idx;
    assign ways[w].tag      = req_tag;
    assign ways[w].word_sel = req_word;
    assign ways[w].tag_wen  = sel && meta_wen;
    assign ways[w].line_wen = sel && line_wen;
    assign ways[w].word_wen = sel && word_wen;
    assign ways[w].valid_in = 1'b1;       // Every installed line is valid
    assign ways[w].dirty_in = !line_wen;  // Refill is clean, writes and init dirty
    assign ways[w].line_in  = refill_line;
    assign ways[w].word_in  = req_data;
  end

  // ------------------------------------------------------------
  // Handshake outputs

  assign cachereq_rdy   = (state == idle);
  assign cacheresp_val  = (state == wait_resp);
  assign cacheresp_type = req_type;
  assign cacheresp_hit  = hit_reg;
  assign memreq_val     = (state == evict_request) || (state == refill_request);
  assign memreq_type    = (state == evict_request) ? mem_write : mem_read;
  assign memresp_rdy    = (state == evict_wait) || (state == refill_wait);
  assign evicting       = (state == evict_prepare) || (state == evict_request) ||
                          (state == evict_wait);

  // Line address of the victim during eviction, else of the request
  assign memreq_addr = {evicting ? evict_tag : req_tag, {`CACHE_OFS_W{1'b0}}};

endmodule

// ==== cache_way.sv ====
// Cache way
// Tag, valid, dirty and line storage of one way with its tag compare

`include "cache_defines.svh"

module cache_way (
  input logic clk,
  input logic reset,
  way_if.way  bus
);
  import cache_pkg::*;

  tag_t  tag_mem  [`CACHE_NUM_SETS];
  line_t line_mem [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_bits;
  logic [`CACHE_NUM_SETS-1:0] dirty_bits;

  logic  cur_valid;
  tag_t  cur_tag;

  // ------------------------------------------------------------
  // State bits

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (bus.tag_wen) begin
      valid_bits[bus.idx] <= bus.valid_in;
      dirty_bits[bus.idx] <= bus.dirty_in;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (bus.tag_wen) begin
      tag_mem[bus.idx] <= bus.tag;
    end
    if (bus.line_wen) begin
      line_mem[bus.idx] <= bus.line_in;  // Whole line on refill
    end else if (bus.word_wen) begin
      line_mem[bus.idx][bus.word_sel*`CACHE_DATA_W +: `CACHE_DATA_W] <= bus.word_in;
    end
  end

  // ------------------------------------------------------------
  // Lookup

  assign cur_valid    = valid_bits[bus.idx];
  assign cur_tag      = tag_mem[bus.idx];

  assign bus.valid    = cur_valid;
  assign bus.dirty    = dirty_bits[bus.idx];
  assign bus.tag_out  = cur_tag;
  assign bus.line_out = line_mem[bus.idx];
  assign bus.match    = cur_valid && (cur_tag == bus.tag);

endmodule

// ==== way_merge.sv ====
// Way merge
// Folds the per-way lookups into hit, response word and victim line

`include "cache_defines.svh"

module way_merge (
  way_if.merge             ways [`CACHE_NUM_WAYS],
  input  cache_pkg::way_t  victim_way,
  input  logic             evicting,
  output logic             hit,
  output cache_pkg::way_t  hit_way,
  output cache_pkg::word_t resp_word,
  output logic             victim_valid,
  output logic             victim_dirty,
  output cache_pkg::tag_t  victim_tag,
  output cache_pkg::line_t victim_line
);
  import cache_pkg::*;

  logic      match_v [`CACHE_NUM_WAYS];
  logic      valid_v [`CACHE_NUM_WAYS];
  logic      dirty_v [`CACHE_NUM_WAYS];
  tag_t      tag_v   [`CACHE_NUM_WAYS];
  line_t     line_v  [`CACHE_NUM_WAYS];
  word_sel_t word_sel;

  for (genvar w = 0; w < `CACHE_NUM_WAYS; w++) begin : g_gather
    assign match_v[w] = ways[w].match;
    assign valid_v[w] = ways[w].valid;
    assign dirty_v[w] = ways[w].dirty;
    assign tag_v[w]   = ways[w].tag_out;
    assign line_v[w]  = ways[w].line_out;
  end

  assign word_sel = ways[0].word_sel;  // Same in every way

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (match_v[w]) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  assign resp_word    = line_v[hit_way][word_sel*`CACHE_DATA_W +: `CACHE_DATA_W];

  assign victim_valid = valid_v[victim_way];
  assign victim_dirty = dirty_v[victim_way];
  assign victim_tag   = tag_v[victim_way];
  assign victim_line  = evicting ? line_v[victim_way] : '0;  // Writeback data

endmodule

// ==== blocking_cache.sv ====
// Blocking data cache top level
// Two-way set-associative write-back cache with valid/ready ports

`include "cache_defines.svh"

module blocking_cache (
  input  logic                 clk,
  input  logic                 reset,

  // Cache request
  input  logic                 cachereq_val,
  output logic                 cachereq_rdy,
  input  cache_pkg::req_type_e cachereq_type,
  input  cache_pkg::addr_t     cachereq_addr,
  input  cache_pkg::word_t     cachereq_data,

  // Cache response
  output logic                 cacheresp_val,
  input  logic                 cacheresp_rdy,
  output cache_pkg::req_type_e cacheresp_type,
  output cache_pkg::word_t     cacheresp_data,
  output logic                 cacheresp_hit,

  // Memory request
  output logic                 memreq_val,
  input  logic                 memreq_rdy,
  output cache_pkg::mem_type_e memreq_type,
  output cache_pkg::addr_t     memreq_addr,
  output cache_pkg::line_t     memreq_data,

  // Memory response
  input  logic                 memresp_val,
  output logic                 memresp_rdy,
  input  cache_pkg::line_t     memresp_data
);
  import cache_pkg::*;

  logic hit;
  way_t hit_way;
  way_t victim_way;
  logic victim_valid;
  logic victim_dirty;
  tag_t victim_tag;
  logic evicting;

  way_if way_bus [`CACHE_NUM_WAYS] ();

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .cacheresp_type (cacheresp_type),
    .cacheresp_hit  (cacheresp_hit),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_type    (memreq_type),
    .memreq_addr    (memreq_addr),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_data   (memresp_data),
    .hit            (hit),
    .hit_way        (hit_way),
    .victim_valid   (victim_valid),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .victim_way     (victim_way),
    .evicting       (evicting),
    .ways           (way_bus)
  );

  // One storage block per way
  for (genvar w = 0; w < `CACHE_NUM_WAYS; w++) begin : g_ways
    cache_way u_way (
      .clk   (clk),
      .reset (reset),
      .bus   (way_bus[w])
    );
  end

  way_merge u_merge (
    .ways         (way_bus),
    .victim_way   (victim_way),
    .evicting     (evicting),
    .hit          (hit),
    .hit_way      (hit_way),
    .resp_word    (cacheresp_data),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (memreq_data)
  );

endmodule

// ==== tb_mem_model.sv ====
// Testbench main memory
// Line storage with random request acceptance and random response delay

module tb_mem_model (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 memreq_val,
  output logic                 memreq_rdy,
  input  cache_pkg::mem_type_e memreq_type,
  input  cache_pkg::addr_t     memreq_addr,
  input  cache_pkg::line_t     memreq_data,
  output logic                 memresp_val,
  input  logic                 memresp_rdy,
  output cache_pkg::line_t     memresp_data
);
  import cache_pkg::*;

  line_t     lines [addr_t];  // Written lines only, keyed by line address
  integer    seed = 13147;
  int        accept_wait = 0;
  int        resp_wait = 0;
  logic      busy = 1'b0;
  logic      rdy_q = 1'b0;
  logic      resp_val_q = 1'b0;
  line_t     resp_data_q = '0;
  mem_type_e pend_type = mem_read;
  addr_t     pend_addr = '0;

  assign memreq_rdy   = rdy_q;
  assign memresp_val  = resp_val_q;
  assign memresp_data = resp_data_q;

  // Untouched memory holds a pattern of the word address
  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h3C5A_A5C3;
  endfunction

  function automatic line_t read_line(addr_t a);
    line_t l;
    if (lines.exists(a)) return lines[a];
    for (int i = 0; i < 4; i++) l[i*32 +: 32] = fill_word(a + addr_t'(i * 4));
    return l;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      rdy_q      <= 1'b0;
      resp_val_q <= 1'b0;
      busy       <= 1'b0;
    end else if (resp_val_q) begin
      if (memresp_rdy) resp_val_q <= 1'b0;  // Response taken
    end else if (busy) begin
      if (resp_wait == 0) begin
        resp_val_q  <= 1'b1;
        resp_data_q <= (pend_type == mem_read) ? read_line(pend_addr) : '0;
        busy        <= 1'b0;
      end else begin
        resp_wait <= resp_wait - 1;
      end
    end else if (memreq_val && rdy_q) begin
      if (memreq_type == mem_write) lines[memreq_addr] = memreq_data;
      pend_type   <= memreq_type;
      pend_addr   <= memreq_addr;
      rdy_q       <= 1'b0;
      busy        <= 1'b1;
      resp_wait   <= $random(seed) & 3;
      accept_wait <= $random(seed) & 3;
    end else if (memreq_val) begin
      if (accept_wait == 0) rdy_q <= 1'b1;
      else accept_wait <= accept_wait - 1;
    end
  end

endmodule

// ==== tb_cache.sv ====
// Testbench for the blocking cache
// Directed and random requests checked against a shadow copy of memory

module tb_cache;
  import cache_pkg::*;

  localparam int TIMEOUT = 500;  // Cycles per wait

  logic      clk;
  logic      reset;
  logic      cachereq_val;
  logic      cachereq_rdy;
  req_type_e cachereq_type;
  addr_t     cachereq_addr;
  word_t     cachereq_data;
  logic      cacheresp_val;
  logic      cacheresp_rdy = 1'b1;
  req_type_e cacheresp_type;
  word_t     cacheresp_data;
  logic      cacheresp_hit;
  logic      memreq_val;
  logic      memreq_rdy;
  mem_type_e memreq_type;
  addr_t     memreq_addr;
  line_t     memreq_data;
  logic      memresp_val;
  logic      memresp_rdy;
  line_t     memresp_data;

  integer    seed = 13147;
  integer    rdy_seed = 13147;
  logic      rdy_random = 1'b0;
  int        cyc = 0;
  int        errors = 0;

  // Shadow memory and outstanding expectations
  word_t     shadow [addr_t];
  req_type_e exp_type_q [$];
  word_t     exp_data_q [$];
  int        exp_hit_q [$];   // -1 leaves the hit flag unchecked
  string     exp_name_q [$];

  int        resp_count = 0;
  int        last_resp_cyc = 0;
  int        accept_cyc = 0;
  int        wb_count = 0;
  addr_t     wb_addr = '0;
  line_t     wb_data = '0;
  int        memreq_cycles = 0;

  blocking_cache dut (.*);

  tb_mem_model u_mem (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_type  (memreq_type),
    .memreq_addr  (memreq_addr),
    .memreq_data  (memreq_data),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_data (memresp_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Response back-pressure
  always @(posedge clk) begin
    cacheresp_rdy <= rdy_random ? (($random(rdy_seed) & 1) != 0) : 1'b1;
  end

  // ------------------------------------------------------------
  // Reference and checks

  function automatic word_t expected_word(addr_t addr);
    addr_t a;
    a = {addr[31:2], 2'b00};
    if (shadow.exists(a)) return shadow[a];
    return (a * 32'h9E37_79B1) ^ 32'h3C5A_A5C3;  // Memory fill pattern
  endfunction

  function automatic line_t expected_line(addr_t line_addr);
    line_t l;
    for (int i = 0; i < 4; i++) l[i*32 +: 32] = expected_word(line_addr + addr_t'(i * 4));
    return l;
  endfunction

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      end_with_failure();
    end
  endtask

  // Compare every accepted response with the oldest expectation
  always @(posedge clk) begin : compare_resp
    string     name;
    req_type_e kind;
    word_t     data;
    int        want_hit;
    if (!reset && cacheresp_val && cacheresp_rdy) begin
      if (exp_type_q.size() == 0) begin
        $display("ERROR: a response arrived with no request outstanding");
        end_with_failure();
      end else begin
        name     = exp_name_q.pop_front();
        kind     = exp_type_q.pop_front();
        data     = exp_data_q.pop_front();
        want_hit = exp_hit_q.pop_front();
        check_value({name, " type"}, 128'(kind), 128'(cacheresp_type));
        if (kind == req_read) check_value({name, " data"}, 128'(data), 128'(cacheresp_data));
        if (want_hit >= 0) check_value({name, " hit"}, 128'(want_hit), 128'(cacheresp_hit));
        resp_count    <= resp_count + 1;
        last_resp_cyc <= cyc;
      end
    end
  end

  // Memory request monitor
  always @(posedge clk) begin
    if (!reset && memreq_val) begin
      memreq_cycles <= memreq_cycles + 1;
      if (memreq_rdy && memreq_type == mem_write) begin
        wb_count <= wb_count + 1;
        wb_addr  <= memreq_addr;
        wb_data  <= memreq_data;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus

  task automatic send_req(input string name, input req_type_e kind, input addr_t addr,
                          input word_t data, input int want_hit);
    int n;
    int prev;
    prev          = resp_count;
    cachereq_val  <= 1'b1;
    cachereq_type <= kind;
    cachereq_addr <= addr;
    cachereq_data <= data;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("request acceptance");
    end while (!cachereq_rdy);
    cachereq_val <= 1'b0;
    accept_cyc   = cyc;
    if (kind != req_read) shadow[{addr[31:2], 2'b00}] = data;
    exp_name_q.push_back(name);
    exp_type_q.push_back(kind);
    exp_data_q.push_back(expected_word(addr));
    exp_hit_q.push_back(want_hit);
    n = 0;
    while (resp_count == prev) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("the cache response");
    end
  endtask

  initial begin
    logic [31:0] rnd;
    addr_t       a;
    int          wb_before;
    int          memreq_before;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = req_read;
    cachereq_addr = '0;
    cachereq_data = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    check_value("reset cachereq_rdy", 128'(1), 128'(cachereq_rdy));
    check_value("reset cacheresp_val", 128'(0), 128'(cacheresp_val));
    check_value("reset memreq_val", 128'(0), 128'(memreq_val));
    check_value("reset memresp_rdy", 128'(0), 128'(memresp_rdy));

    // Cold miss, then a hit with fixed latency
    send_req("cold read", req_read, 32'h0000_0104, '0, 0);
    send_req("warm read", req_read, 32'h0000_0104, '0, 1);
    check_value("hit latency", 128'(3), 128'(last_resp_cyc - accept_cyc));

    // Write hit leaves the neighbours untouched
    send_req("write hit", req_write, 32'h0000_0108, 32'hDEAD_BEEF, 1);
    send_req("read back", req_read, 32'h0000_0108, '0, 1);
    send_req("neighbour word", req_read, 32'h0000_010C, '0, 1);
    send_req("first word", req_read, 32'h0000_0100, '0, 1);

    // Three tags in set 2 where the third evicts the dirty first line
    send_req("set2 tag0 write", req_write, 32'h0000_1020, 32'h1111_0000, 0);
    send_req("set2 tag0 write2", req_write, 32'h0000_1028, 32'h1111_0002, 1);
    send_req("set2 tag1 write", req_write, 32'h0000_10A0, 32'h2222_0000, 0);
    wb_before = wb_count;
    send_req("set2 tag2 write", req_write, 32'h0000_1120, 32'h3333_0000, 0);
    check_value("writeback count", 128'(wb_before + 1), 128'(wb_count));
    check_value("writeback addr", 128'(32'h0000_1020), 128'(wb_addr));
    check_value("writeback line", expected_line(32'h0000_1020), wb_data);
    send_req("set2 tag0 reread", req_read, 32'h0000_1020, '0, 0);
    send_req("set2 tag0 reread2", req_read, 32'h0000_1028, '0, 1);

    // Init of a whole line with no memory traffic
    memreq_before = memreq_cycles;
    for (int i = 0; i < 4; i++) begin
      send_req($sformatf("init %0d", i), req_init, 32'h0000_2050 + addr_t'(i * 4),
               32'hA000_0000 + word_t'(i), 0);
    end
    for (int i = 0; i < 4; i++) begin
      send_req($sformatf("init read %0d", i), req_read, 32'h0000_2050 + addr_t'(i * 4),
               '0, 1);
    end
    check_value("init memreq cycles", 128'(memreq_before), 128'(memreq_cycles));

    // Random traffic over 4 sets and 4 tags
    rdy_random <= 1'b1;
    for (int i = 0; i < 300; i++) begin
      rnd = $random(seed);
      a   = 32'h0004_0000 + addr_t'(rnd[3:2]) * 32'h80 + addr_t'(rnd[5:4]) * 32'h10 +
            addr_t'(rnd[7:6]) * 32'h4;
      if (rnd[8]) begin
        send_req($sformatf("random write %0d", i), req_write, a, $random(seed), -1);
      end else begin
        send_req($sformatf("random read %0d", i), req_read, a, '0, -1);
      end
    end
    rdy_random <= 1'b0;
    @(posedge clk);

    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      end_with_failure();
    end
  end

endmodule

// ==== build.f ====
+incdir+.
cache_pkg.sv
way_if.sv
cache_ctrl.sv
cache_way.sv
way_merge.sv
blocking_cache.sv
tb_mem_model.sv
tb_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_cache
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the simulation prints the pass message
run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
